// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_cam_top
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_cam_top.sv
// ====================================================================
// Camera snapshot testbench
// Directed tests for reset, arming, capture, quantizer edges and
// recapture, with LFSR pixels, serial sampler and cycle timeout
// ====================================================================
`timescale 1ns/100ps
`include "cam_consts.svh"

module tb_cam_top;

  localparam int CLK_HALF     = 4;
  localparam int LINES        = 30;
  localparam int PER_LINE     = 32;
  localparam int LINE_GAP     = 8;
  localparam int FRAME_GAP    = 16;
  localparam int FRAME_PIXELS = LINES * PER_LINE;
  localparam int FRAME_CYCLES = LINES * (PER_LINE + LINE_GAP) + 2 * FRAME_GAP;
  // Serial time per byte plus a few cycles of read latency
  localparam int BYTE_CYCLES  = 10 * `BAUD_DIV + 4;
  localparam int TIMEOUT_CYCLES = 3 * `IMG_PIXELS * BYTE_CYCLES + 8 * FRAME_CYCLES;

  logic                CLOCK_50;
  logic                KEY;
  logic                snap_n;
  logic                clear_n;
  cam_pkg::sensor_in_t sensor;
  logic                sensor_reset_n;
  logic                sensor_trigger;
  logic                txd;
  cam_pkg::status_t    status;

  // Frame contents and the digits they should turn into
  cam_pkg::pixel_t frame_pix [0:FRAME_PIXELS-1];
  cam_pkg::char_t  exp_chars [0:`IMG_PIXELS-1];

  logic [31:0] lfsr_state;
  int          check_count;
  int          error_count;
  int          cycle_count;
  int          txd_low_cycles;

  cam_top uut (
    .CLOCK_50(CLOCK_50), .KEY(KEY), .snap_n(snap_n), .clear_n(clear_n),
    .sensor(sensor), .sensor_reset_n(sensor_reset_n),
    .sensor_trigger(sensor_trigger), .txd(txd), .status(status)
  );

  always #CLK_HALF CLOCK_50 = ~CLOCK_50;

  // ==================================================================
  // Timeout and line activity
  // ==================================================================
  always @(posedge CLOCK_50) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped responding", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Any low cycle on txd counts as serial activity
  always @(negedge CLOCK_50) begin
    if (!txd) begin
      txd_low_cycles <= txd_low_cycles + 1;
    end
  end

  // ==================================================================
  // Stimulus helpers
  // ==================================================================
  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // Random value shifted by a random range so every digit shows up
  function automatic cam_pkg::pixel_t random_pixel();
    cam_pkg::pixel_t value;
    logic [1:0]      range;
    for (int b = 0; b < `PIXEL_W; b++) begin
      value[b] = lfsr_bit();
    end
    range[0] = lfsr_bit();
    range[1] = lfsr_bit();
    case (range)
      2'd1:    value = value >> 4;
      2'd2:    value = value >> 7;
      2'd3:    value = value >> 8;
      default: value = value;
    endcase
    return value;
  endfunction

  // Digit of the highest threshold strictly exceeded
  function automatic cam_pkg::char_t expected_digit(input cam_pkg::pixel_t p);
    int value;
    value = int'(p);
    if (value > `THR_HI) return `DIGIT_BASE + 8'd3;
    if (value > `THR_MID) return `DIGIT_BASE + 8'd2;
    if (value > `THR_LO) return `DIGIT_BASE + 8'd1;
    return `DIGIT_BASE;
  endfunction

  task automatic fill_random_frame();
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      frame_pix[i] = random_pixel();
    end
    for (int i = 0; i < `IMG_PIXELS; i++) begin
      exp_chars[i] = expected_digit(frame_pix[i]);
    end
  endtask

  // Threshold edges in pairs that each map to one digit
  task automatic fill_edge_frame();
    cam_pkg::pixel_t edges [0:7];
    edges = '{12'd0, 12'd7, 12'd8, 12'd15, 12'd16, 12'd127, 12'd128, 12'd4095};
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      frame_pix[i] = edges[i % 8];
    end
    for (int i = 0; i < `IMG_PIXELS; i++) begin
      exp_chars[i] = cam_pkg::char_t'(`DIGIT_BASE + (i % 8) / 2);
    end
  endtask

  // Whole frame with fval leading and trailing the lines
  task automatic drive_frame();
    int idx;
    idx = 0;
    @(negedge CLOCK_50);
    sensor.fval = 1'b1;
    sensor.lval = 1'b0;
    repeat (FRAME_GAP) @(negedge CLOCK_50);
    for (int line = 0; line < LINES; line++) begin
      for (int px = 0; px < PER_LINE; px++) begin
        sensor.lval = 1'b1;
        sensor.data = frame_pix[idx];
        idx++;
        @(negedge CLOCK_50);
      end
      sensor.lval = 1'b0;
      sensor.data = '0;
      repeat (LINE_GAP) @(negedge CLOCK_50);
    end
    sensor.fval = 1'b0;
    repeat (FRAME_GAP) @(negedge CLOCK_50);
  endtask

  task automatic pulse_snap();
    @(negedge CLOCK_50);
    snap_n = 1'b0;
    @(negedge CLOCK_50);
    snap_n = 1'b1;
  endtask

  task automatic pulse_clear();
    @(negedge CLOCK_50);
    clear_n = 1'b0;
    @(negedge CLOCK_50);
    clear_n = 1'b1;
  endtask

  // ==================================================================
  // Serial sampler and compare tasks
  // ==================================================================
  task automatic check_char(input string name, input cam_pkg::char_t got,
                            input cam_pkg::char_t exp);
    check_count++;
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // Start bit edge then mid-bit samples
  task automatic receive_byte(output cam_pkg::char_t value);
    @(negedge CLOCK_50);
    while (txd) @(negedge CLOCK_50);
    repeat (`BAUD_DIV / 2 - 1) @(negedge CLOCK_50);
    if (txd) begin
      $display("start bit on txd ended before its middle");
      error_count++;
    end
    for (int b = 0; b < 8; b++) begin
      repeat (`BAUD_DIV) @(negedge CLOCK_50);
      value[b] = txd;
    end
    repeat (`BAUD_DIV) @(negedge CLOCK_50);
    if (!txd) begin
      $display("stop bit missing on txd");
      error_count++;
    end
  endtask

  task automatic receive_image();
    cam_pkg::char_t got;
    for (int i = 0; i < `IMG_PIXELS; i++) begin
      receive_byte(got);
      check_char($sformatf("txd byte %0d", i), got, exp_chars[i]);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: %0d errors", name, error_count - errors_before);
    end
  endtask

  // ==================================================================
  // Directed tests
  // ==================================================================
  task automatic reset_and_release();
    int errs;
    errs = error_count;
    repeat (4) @(negedge CLOCK_50);
    check_bit("sensor_reset_n", sensor_reset_n, 1'b0);
    check_bit("txd", txd, 1'b1);
    check_bit("sensor_trigger", sensor_trigger, 1'b1);
    check_bit("status.armed", status.armed, 1'b0);
    check_bit("status.captured", status.captured, 1'b0);
    check_bit("status.image_ready", status.image_ready, 1'b0);
    check_bit("status.sent", status.sent, 1'b0);
    repeat (4) @(negedge CLOCK_50);
    KEY = 1'b1;
    // Low until the last count and high exactly on it
    for (int i = 1; i <= `RESET_DELAY; i++) begin
      @(negedge CLOCK_50);
      check_bit($sformatf("sensor_reset_n cycle %0d", i), sensor_reset_n,
                i == `RESET_DELAY);
    end
    report_test("reset", errs);
  endtask

  task automatic arm_snapshot();
    int errs;
    int low_before;
    errs = error_count;
    fill_random_frame();
    low_before = txd_low_cycles;
    drive_frame();
    repeat (10 * `BAUD_DIV) @(negedge CLOCK_50);
    check_bit("txd activity", txd_low_cycles != low_before, 1'b0);
    check_bit("status.captured", status.captured, 1'b0);
    check_bit("status.armed", status.armed, 1'b0);
    snap_n = 1'b0;
    @(negedge CLOCK_50);
    check_bit("status.armed", status.armed, 1'b1);
    check_bit("sensor_trigger", sensor_trigger, 1'b0);
    snap_n = 1'b1;
    @(negedge CLOCK_50);
    check_bit("sensor_trigger", sensor_trigger, 1'b1);
    report_test("arming", errs);
  endtask

  task automatic capture_and_stream();
    int errs;
    errs = error_count;
    fill_random_frame();
    fork
      drive_frame();
      receive_image();
    join
    check_bit("status.captured", status.captured, 1'b1);
    check_bit("status.image_ready", status.image_ready, 1'b1);
    check_bit("sensor_trigger", sensor_trigger, 1'b1);
    check_bit("status.sent", status.sent, 1'b1);
    // Button pressed again after capture and the trigger stays high
    snap_n = 1'b0;
    @(negedge CLOCK_50);
    check_bit("sensor_trigger", sensor_trigger, 1'b1);
    snap_n = 1'b1;
    report_test("capture and stream", errs);
  endtask

  task automatic quantizer_edges();
    int errs;
    errs = error_count;
    pulse_clear();
    pulse_snap();
    fill_edge_frame();
    fork
      drive_frame();
      receive_image();
    join
    check_bit("status.sent", status.sent, 1'b1);
    report_test("quantizer edges", errs);
  endtask

  task automatic clear_and_recapture();
    int errs;
    int low_before;
    errs = error_count;
    pulse_clear();
    check_bit("status.armed", status.armed, 1'b0);
    check_bit("status.captured", status.captured, 1'b0);
    check_bit("status.image_ready", status.image_ready, 1'b0);
    check_bit("status.sent", status.sent, 1'b0);
    pulse_snap();
    fill_random_frame();
    fork
      drive_frame();
      receive_image();
    join
    check_bit("status.sent", status.sent, 1'b1);
    // One capture per clear so a further frame stays silent
    fill_random_frame();
    low_before = txd_low_cycles;
    drive_frame();
    repeat (2 * 10 * `BAUD_DIV) @(negedge CLOCK_50);
    check_bit("txd activity", txd_low_cycles != low_before, 1'b0);
    check_bit("status.sent", status.sent, 1'b1);
    report_test("clear and recapture", errs);
  endtask

  // ==================================================================
  // Main sequence
  // ==================================================================
  initial begin
    CLOCK_50       = 1'b0;
    KEY            = 1'b0;
    snap_n         = 1'b1;
    clear_n        = 1'b1;
    sensor         = '0;
    lfsr_state     = 32'h664e5808;
    check_count    = 0;
    error_count    = 0;
    cycle_count    = 0;
    txd_low_cycles = 0;
    reset_and_release();
    arm_snapshot();
    capture_and_stream();
    quantizer_edges();
    clear_and_recapture();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
source/cam_pkg.sv
source/reset_sequencer.sv
source/capture_trigger.sv
source/pixel_loader.sv
source/image_store.sv
source/pixel_streamer.sv
source/uart_tx.sv
source/cam_top.sv
bench/tb_cam_top.sv

// File: include/cam_consts.svh
// ====================================================================
// Camera snapshot constants
// Image geometry, pixel format, quantizer thresholds,
// serial bit timing and sensor reset delay
// ====================================================================
`ifndef CAM_CONSTS_SVH
`define CAM_CONSTS_SVH

// Image geometry, 28 x 28 snapshot
`define IMG_PIXELS 784
`define ADDR_W 10

// Raw sensor pixel width
`define PIXEL_W 12

// Quantizer thresholds, strictly greater than
`define THR_HI 127
`define THR_MID 15
`define THR_LO 7

// ASCII '0', digits run '0' to '3'
`define DIGIT_BASE 8'h30

// Clock cycles per serial bit
`define BAUD_DIV 8

// Cycles from reset release to sensor release
`define RESET_DELAY 32

`endif

// File: source/cam_pkg.sv
// ====================================================================
// Shared camera capture types
// Pixel, address and byte widths, memory request and status structs,
// loader and streamer state encodings
// ====================================================================
`include "cam_consts.svh"

package cam_pkg;

  // Plain widths with a meaning
  typedef logic [`PIXEL_W-1:0] pixel_t;
  typedef logic [`ADDR_W-1:0]  img_addr_t;
  typedef logic [7:0]          char_t;

  // Image store access, wdata ignored on reads
  typedef struct packed {
    logic      valid;
    img_addr_t addr;
    pixel_t    wdata;
  } mem_req_t;

  // Sensor pins, already on CLOCK_50
  typedef struct packed {
    logic   fval;
    logic   lval;
    pixel_t data;
  } sensor_in_t;

  // Board status flags
  typedef struct packed {
    logic armed;
    logic captured;
    logic image_ready;
    logic sent;
  } status_t;

  typedef enum logic [1:0] {WAIT_FRAME, LOADING, FULL} load_state_e;
  typedef enum logic [1:0] {IDLE, READ, SEND, DONE} stream_state_e;

endpackage

// File: source/cam_top.sv
// ====================================================================
// Camera snapshot top level
// Reset sequencing, capture control, image store and serial output
// ====================================================================
`timescale 1ns/100ps

module cam_top (
  input  logic                CLOCK_50,
  input  logic                KEY,
  input  logic                snap_n,
  input  logic                clear_n,
  input  cam_pkg::sensor_in_t sensor,
  output logic                sensor_reset_n,
  output logic                sensor_trigger,
  output logic                txd,
  output cam_pkg::status_t    status
);

  logic              enable;
  logic              armed;
  logic              captured;
  logic              image_ready;
  logic              sent;
  cam_pkg::mem_req_t wr_req;
  cam_pkg::mem_req_t rd_req;
  logic              wr_grant;
  logic              rd_grant;
  cam_pkg::pixel_t   rd_data;
  logic              tx_start;
  cam_pkg::char_t    tx_char;
  logic              busy;

  // ==================================================================
  // Sensor control
  // ==================================================================
  reset_sequencer u_reset_seq (
    .CLOCK_50(CLOCK_50), .KEY(KEY),
    .sensor_reset_n(sensor_reset_n), .enable(enable)
  );

  capture_trigger u_trigger (
    .CLOCK_50(CLOCK_50), .KEY(KEY), .snap_n(snap_n), .clear_n(clear_n),
    .enable(enable), .fval(sensor.fval),
    .armed(armed), .captured(captured), .sensor_trigger(sensor_trigger)
  );

  // ==================================================================
  // Image path, loader and streamer share the store
  // ==================================================================
  pixel_loader u_loader (
    .CLOCK_50(CLOCK_50), .KEY(KEY), .clear_n(clear_n), .captured(captured),
    .sensor(sensor), .wr_grant(wr_grant), .wr_req(wr_req), .image_ready(image_ready)
  );

  image_store u_store (
    .CLOCK_50(CLOCK_50), .KEY(KEY), .wr_req(wr_req), .rd_req(rd_req),
    .wr_grant(wr_grant), .rd_grant(rd_grant), .rd_data(rd_data)
  );

  pixel_streamer u_streamer (
    .CLOCK_50(CLOCK_50), .KEY(KEY), .clear_n(clear_n), .image_ready(image_ready),
    .rd_grant(rd_grant), .rd_data(rd_data), .busy(busy),
    .rd_req(rd_req), .tx_start(tx_start), .tx_char(tx_char), .sent(sent)
  );

  uart_tx u_uart (
    .CLOCK_50(CLOCK_50), .KEY(KEY), .tx_start(tx_start), .tx_char(tx_char),
    .txd(txd), .busy(busy)
  );

  // Flags for LEDs or the bench
  assign status = '{armed: armed, captured: captured, image_ready: image_ready, sent: sent};

endmodule

// File: source/capture_trigger.sv
// ====================================================================
// Snapshot arm and capture control
// Arm latch, captured flag and the sensor trigger output
// ====================================================================
`timescale 1ns/100ps

module capture_trigger (
  input  logic CLOCK_50,
  input  logic KEY,
  input  logic snap_n,
  input  logic clear_n,
  input  logic enable,
  input  logic fval,
  output logic armed,
  output logic captured,
  output logic sensor_trigger
);

  // Arm latch, clear button wins over snap
  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      armed <= 1'b0;
    end else if (!clear_n) begin
      armed <= 1'b0;
    end else if (!snap_n) begin
      armed <= 1'b1;
    end
  end

  // First frame seen while armed and the sensor is running
  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      captured <= 1'b0;
    end else if (!clear_n) begin
      captured <= 1'b0;
    end else if (fval && armed && enable) begin
      captured <= 1'b1;
    end
  end

  // Trigger low only while the button is held and nothing is captured yet
  assign sensor_trigger = snap_n | captured;

endmodule

// File: source/image_store.sv
// ====================================================================
// Image store
// Single-port pixel memory shared by loader and streamer,
// fixed-priority arbiter with the writer first
// ====================================================================
`timescale 1ns/100ps
`include "cam_consts.svh"

module image_store (
  input  logic              CLOCK_50,
  input  logic              KEY,
  input  cam_pkg::mem_req_t wr_req,
  input  cam_pkg::mem_req_t rd_req,
  output logic              wr_grant,
  output logic              rd_grant,
  output cam_pkg::pixel_t   rd_data
);

  // One pixel per image position
  cam_pkg::pixel_t mem [`IMG_PIXELS];

  // ==================================================================
  // Arbiter
  // ==================================================================
  // Writer always wins, reader only gets idle cycles
  assign wr_grant = wr_req.valid;
  assign rd_grant = rd_req.valid && !wr_req.valid;

  // ==================================================================
  // Memory array
  // ==================================================================
  always_ff @(posedge CLOCK_50) begin
    if (wr_grant) begin
      mem[wr_req.addr] <= wr_req.wdata;
    end
  end

  // Read data lands the cycle after the grant
  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      rd_data <= '0;
    end else if (rd_grant) begin
      rd_data <= mem[rd_req.addr];
    end
  end

endmodule

// File: source/pixel_loader.sv
// ====================================================================
// Pixel loader
// Windows the captured frame and writes its first image's worth of
// valid pixels into the image store through the write port
// ====================================================================
`timescale 1ns/100ps
`include "cam_consts.svh"

module pixel_loader (
  input  logic                CLOCK_50,
  input  logic                KEY,
  input  logic                clear_n,
  input  logic                captured,
  input  cam_pkg::sensor_in_t sensor,
  input  logic                wr_grant,
  output cam_pkg::mem_req_t   wr_req,
  output logic                image_ready
);

  localparam cam_pkg::img_addr_t LAST_ADDR = cam_pkg::img_addr_t'(`IMG_PIXELS - 1);
  localparam cam_pkg::img_addr_t END_ADDR  = cam_pkg::img_addr_t'(`IMG_PIXELS);

  cam_pkg::load_state_e state;
  cam_pkg::sensor_in_t  sensor_q;
  logic                 fval_prev;
  cam_pkg::mem_req_t    hold;
  cam_pkg::mem_req_t    new_req;
  cam_pkg::img_addr_t   next_addr;
  logic                 frame_start;
  logic                 take_pixel;
  logic                 slot_free;
  logic                 last_write;

  // ==================================================================
  // Frame window
  // ==================================================================
  // Input stage delays fval so captured is already set at the frame edge
  assign frame_start = sensor_q.fval && !fval_prev && captured;
  assign take_pixel  = sensor_q.fval && sensor_q.lval && (next_addr != END_ADDR) &&
                       ((state == cam_pkg::LOADING) ||
                        ((state == cam_pkg::WAIT_FRAME) && frame_start));

  // Request slot frees up in the cycle it is granted
  assign slot_free  = !wr_req.valid || wr_grant;
  assign last_write = wr_req.valid && wr_grant && (wr_req.addr == LAST_ADDR);
  assign new_req    = '{valid: 1'b1, addr: next_addr, wdata: sensor_q.data};

  assign image_ready = (state == cam_pkg::FULL);

  // ==================================================================
  // State, address and write request
  // ==================================================================
  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      state     <= cam_pkg::WAIT_FRAME;
      sensor_q  <= '0;
      fval_prev <= 1'b0;
      wr_req    <= '0;
      hold      <= '0;
      next_addr <= '0;
    end else begin
      sensor_q  <= sensor;
      fval_prev <= sensor_q.fval;
      if (!clear_n) begin
        state     <= cam_pkg::WAIT_FRAME;
        wr_req    <= '0;
        hold      <= '0;
        next_addr <= '0;
      end else begin
        case (state)
          cam_pkg::WAIT_FRAME: if (frame_start) state <= cam_pkg::LOADING;
          cam_pkg::LOADING:    if (last_write) state <= cam_pkg::FULL;
          default:             state <= state;
        endcase
        // Held pixel goes first, new one queues behind it
        if (slot_free) begin
          if (hold.valid) begin
            wr_req <= hold;
            hold   <= take_pixel ? new_req : '0;
          end else begin
            wr_req <= take_pixel ? new_req : '0;
          end
        end else if (take_pixel) begin
          // Write still pending, park the pixel
          hold <= new_req;
        end
        if (take_pixel) begin
          next_addr <= next_addr + 1'b1;
        end
      end
    end
  end

endmodule

// File: source/pixel_streamer.sv
// ====================================================================
// Pixel streamer
// Reads the stored image in address order, quantizes each pixel
// to an ASCII digit and hands it to the serial transmitter
// ====================================================================
`timescale 1ns/100ps
`include "cam_consts.svh"

module pixel_streamer (
  input  logic              CLOCK_50,
  input  logic              KEY,
  input  logic              clear_n,
  input  logic              image_ready,
  input  logic              rd_grant,
  input  cam_pkg::pixel_t   rd_data,
  input  logic              busy,
  output cam_pkg::mem_req_t rd_req,
  output logic              tx_start,
  output cam_pkg::char_t    tx_char,
  output logic              sent
);

  localparam cam_pkg::img_addr_t LAST_ADDR = cam_pkg::img_addr_t'(`IMG_PIXELS - 1);

  cam_pkg::stream_state_e state;
  cam_pkg::img_addr_t     addr;
  logic                   data_valid;

  // Four brightness levels, '0' darkest
  function automatic cam_pkg::char_t quantize(input cam_pkg::pixel_t p);
    cam_pkg::char_t level;
    if (p > cam_pkg::pixel_t'(`THR_HI)) begin
      level = 8'd3;
    end else if (p > cam_pkg::pixel_t'(`THR_MID)) begin
      level = 8'd2;
    end else if (p > cam_pkg::pixel_t'(`THR_LO)) begin
      level = 8'd1;
    end else begin
      level = 8'd0;
    end
    return `DIGIT_BASE + level;
  endfunction

  // Single read per address, dropped once the grant is back
  assign rd_req   = '{valid: (state == cam_pkg::READ) && !data_valid, addr: addr, wdata: '0};
  // Digit goes out once the transmitter is free
  assign tx_start = (state == cam_pkg::SEND) && !busy;
  assign sent     = (state == cam_pkg::DONE);

  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      state      <= cam_pkg::IDLE;
      addr       <= '0;
      data_valid <= 1'b0;
    end else begin
      data_valid <= rd_grant;
      if (!clear_n) begin
        state <= cam_pkg::IDLE;
      end else begin
        case (state)
          cam_pkg::IDLE: begin
            if (image_ready) begin
              addr  <= '0;
              state <= cam_pkg::READ;
            end
          end
          cam_pkg::READ: if (data_valid) state <= cam_pkg::SEND;
          cam_pkg::SEND: begin
            if (!busy) begin
              if (addr == LAST_ADDR) begin
                state <= cam_pkg::DONE;
              end else begin
                addr  <= addr + 1'b1;
                state <= cam_pkg::READ;
              end
            end
          end
          // Stays here until clear, one pass per capture
          cam_pkg::DONE: state <= cam_pkg::DONE;
        endcase
      end
    end
  end

  // Digit held steady through back-pressure
  always_ff @(posedge CLOCK_50) begin
    if ((state == cam_pkg::READ) && data_valid) begin
      tx_char <= quantize(rd_data);
    end
  end

endmodule

// File: source/reset_sequencer.sv
// ====================================================================
// Power-on reset sequencer
// Holds the sensor in reset for a fixed delay after KEY release
// ====================================================================
`timescale 1ns/100ps
`include "cam_consts.svh"

module reset_sequencer (
  input  logic CLOCK_50,
  input  logic KEY,
  output logic sensor_reset_n,
  output logic enable
);

  localparam int CNT_W = $clog2(`RESET_DELAY);

  // Delay counter, saturates once released
  logic [CNT_W-1:0] delay_cnt;
  logic             released;

  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      delay_cnt <= '0;
      released  <= 1'b0;
    end else if (!released) begin
      // Last count reached, release on this edge
      if (delay_cnt == CNT_W'(`RESET_DELAY - 1)) begin
        released <= 1'b1;
      end else begin
        delay_cnt <= delay_cnt + 1'b1;
      end
    end
  end

  // Sensor and capture logic come out of reset together
  assign sensor_reset_n = released;
  assign enable         = released;

endmodule

// File: source/uart_tx.sv
// ====================================================================
// Serial transmitter, 8N1
// Fixed baud divisor, start bit, eight data bits LSB first, stop bit
// ====================================================================
`timescale 1ns/100ps
`include "cam_consts.svh"

module uart_tx (
  input  logic           CLOCK_50,
  input  logic           KEY,
  input  logic           tx_start,
  input  cam_pkg::char_t tx_char,
  output logic           txd,
  output logic           busy
);

  localparam int BAUD_W = $clog2(`BAUD_DIV);

  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_cnt;
  // Stop, data, start, shifted out from bit 0
  logic [9:0]        shifter;
  logic              baud_tick;

  assign baud_tick = (baud_cnt == BAUD_W'(`BAUD_DIV - 1));
  // Line idles high through the ones shifted in behind the frame
  assign txd = shifter[0];

  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      shifter  <= '1;
    end else if (!busy) begin
      // Start only honoured while idle
      if (tx_start) begin
        shifter  <= {1'b1, tx_char, 1'b0};
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
    end else if (baud_tick) begin
      baud_cnt <= '0;
      shifter  <= {1'b1, shifter[9:1]};
      // End of stop bit
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule
